// File: hw/vread_defs.svh
`ifndef VREAD_DEFS_SVH
`define VREAD_DEFS_SVH

// word width of the databus, buffer and flow output
`define VR_DATA_W 32

// external byte address
`define VR_IO_ADDR_W 32

// buffer holds 64 words
`define VR_MEM_ADDR_W 6

// transfer length up to a full buffer
`define VR_SIZE_W 7

// period, duty and delay
`define VR_PERIOD_W 5

// AXI4-Lite register address
`define VR_REG_ADDR_W 6

`endif

// File: hw/vreadPkg.sv
`default_nettype none

`include "vread_defs.svh"

package vreadPkg;

   typedef logic [`VR_MEM_ADDR_W-1:0] memAddrT;

   // fetch fields first, then the stream side
   typedef struct packed {
      logic [`VR_IO_ADDR_W-1:0] extAddr;
      memAddrT                  intAddr;
      logic [`VR_SIZE_W-1:0]    size;
      memAddrT                  iter;
      logic [`VR_PERIOD_W-1:0]  per;
      logic [`VR_PERIOD_W-1:0]  duty;
      logic [`VR_PERIOD_W-1:0]  delay;
      memAddrT                  start;
      memAddrT                  incr;
      memAddrT                  shift;
      memAddrT                  iter2;
      memAddrT                  incr2;
      logic                     reverse;
   } vreadCfgT;

endpackage

`default_nettype wire

// File: hw/memPortIf.sv
`default_nettype none

`include "vread_defs.svh"

interface memPortIf;

   logic                    wrEn;
   vreadPkg::memAddrT       wrAddr;
   logic [`VR_DATA_W-1:0]   wrData;
   logic                    rdEn;
   vreadPkg::memAddrT       rdAddr;
   logic [`VR_DATA_W-1:0]   rdData;

   modport fill (output wrEn, wrAddr, wrData);
   modport drain (output rdEn, rdAddr);
   modport store (input wrEn, wrAddr, wrData, rdEn, rdAddr, output rdData);

endinterface

`default_nettype wire

// File: hw/streamBuffer.sv
`default_nettype none

`include "vread_defs.svh"

module streamBuffer (
   input  logic         clk,
   memPortIf.store      mem
);

   localparam int depth = 1 << `VR_MEM_ADDR_W;

   logic [`VR_DATA_W-1:0] ram [depth];

   always_ff @(posedge clk)
   begin
      if (mem.wrEn)
         ram[mem.wrAddr] <= mem.wrData;
   end

   // registered read with one cycle latency
   always_ff @(posedge clk)
   begin
      if (mem.rdEn)
         mem.rdData <= ram[mem.rdAddr];
   end

endmodule

`default_nettype wire

// File: hw/extReadEngine.sv
`default_nettype none

`include "vread_defs.svh"

module extReadEngine (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic                        run,
   input  vreadPkg::vreadCfgT          cfg,
   output logic                        finish,
   output logic                        databusValid,
   output logic [`VR_IO_ADDR_W-1:0]    databusAddr,
   input  logic                        databusReady,
   input  logic [`VR_DATA_W-1:0]       databusRdata,
   memPortIf.fill                      mem
);

   logic [`VR_SIZE_W-1:0]   left;
   vreadPkg::memAddrT       wrPtr;
   logic                    xfer;

   assign xfer = databusValid & databusReady;

   // rdata is valid in the handshake cycle, so write it straight through
   assign mem.wrEn   = xfer;
   assign mem.wrAddr = wrPtr;
   assign mem.wrData = databusRdata;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         databusValid <= 1'b0;
         databusAddr  <= '0;
         wrPtr        <= '0;
         left         <= '0;
         finish       <= 1'b0;
      end
      else
      begin
         finish <= 1'b0;
         if (run && !databusValid)
         begin
            databusAddr  <= cfg.extAddr;
            wrPtr        <= cfg.intAddr;
            left         <= cfg.size;
            databusValid <= cfg.size != '0;
            // empty transfer finishes at once
            finish       <= cfg.size == '0;
         end
         else if (xfer)
         begin
            databusAddr <= databusAddr + `VR_IO_ADDR_W'd4;
            wrPtr       <= wrPtr + 1'b1;
            left        <= left - 1'b1;
            if (left == `VR_SIZE_W'd1)
            begin
               databusValid <= 1'b0;
               finish       <= 1'b1;
            end
         end
      end
   end

   // request held over ready stalls
   reqHeld: assert property (@(posedge clk) disable iff (!arstN)
      databusValid && !databusReady |=> databusValid && $stable(databusAddr));

endmodule

`default_nettype wire

// File: hw/streamAddrGen.sv
`default_nettype none

`include "vread_defs.svh"

module streamAddrGen (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  run,
   input  vreadPkg::vreadCfgT    cfg,
   output logic                  finish,
   memPortIf.drain               mem
);

   typedef enum logic [1:0] {sIdle, sDelay, sActive} stateT;

   stateT                     state;
   logic [`VR_PERIOD_W-1:0]   delayCnt;
   logic [`VR_PERIOD_W-1:0]   phase;
   vreadPkg::memAddrT         inner;
   vreadPkg::memAddrT         outer;
   vreadPkg::memAddrT         outerBase;
   vreadPkg::memAddrT         periodBase;
   vreadPkg::memAddrT         addrAcc;
   logic                      periodEnd;
   logic                      lastInner;
   logic                      lastOuter;

   function automatic vreadPkg::memAddrT bitRev(input vreadPkg::memAddrT a);
      vreadPkg::memAddrT r;
      for (int b = 0; b < `VR_MEM_ADDR_W; b++)
         r[b] = a[`VR_MEM_ADDR_W-1-b];
      return r;
   endfunction

   assign periodEnd = phase == cfg.per - 1'b1;
   assign lastInner = inner == cfg.iter - 1'b1;
   assign lastOuter = outer == cfg.iter2 - 1'b1;

   // step k equals the period phase
   assign mem.rdEn   = state == sActive && phase < cfg.duty;
   assign mem.rdAddr = cfg.reverse ? bitRev(addrAcc) : addrAcc;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state      <= sIdle;
         finish     <= 1'b0;
         delayCnt   <= '0;
         phase      <= '0;
         inner      <= '0;
         outer      <= '0;
         outerBase  <= '0;
         periodBase <= '0;
         addrAcc    <= '0;
      end
      else
      begin
         finish <= 1'b0;
         case (state)
            sIdle:
               if (run)
               begin
                  phase      <= '0;
                  inner      <= '0;
                  outer      <= '0;
                  outerBase  <= cfg.start;
                  periodBase <= cfg.start;
                  addrAcc    <= cfg.start;
                  delayCnt   <= cfg.delay;
                  state      <= cfg.delay == '0 ? sActive : sDelay;
               end
            sDelay:
            begin
               delayCnt <= delayCnt - 1'b1;
               if (delayCnt == `VR_PERIOD_W'd1)
                  state <= sActive;
            end
            sActive:
               if (!periodEnd)
               begin
                  phase   <= phase + 1'b1;
                  addrAcc <= addrAcc + cfg.incr;
               end
               else
               begin
                  phase <= '0;
                  if (!lastInner)
                  begin
                     inner      <= inner + 1'b1;
                     periodBase <= periodBase + cfg.shift;
                     addrAcc    <= periodBase + cfg.shift;
                  end
                  else if (!lastOuter)
                  begin
                     inner      <= '0;
                     outer      <= outer + 1'b1;
                     outerBase  <= outerBase + cfg.incr2;
                     periodBase <= outerBase + cfg.incr2;
                     addrAcc    <= outerBase + cfg.incr2;
                  end
                  else
                  begin
                     state  <= sIdle;
                     finish <= 1'b1;
                  end
               end
            default:
               state <= sIdle;
         endcase
      end
   end

   // reads stay inside the programmed iteration space
   inRange: assert property (@(posedge clk) disable iff (!arstN)
      mem.rdEn |-> inner < cfg.iter && outer < cfg.iter2);

endmodule

`default_nettype wire

// File: hw/vreadCtrl.sv
`default_nettype none

`include "vread_defs.svh"

module vreadCtrl (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic [`VR_REG_ADDR_W-1:0]   awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [`VR_DATA_W-1:0]       wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [`VR_REG_ADDR_W-1:0]   araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [`VR_DATA_W-1:0]       rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   input  logic                        finishA,
   input  logic                        finishB,
   output logic                        runA,
   output logic                        runB,
   output vreadPkg::vreadCfgT          cfg
);

   localparam logic [`VR_REG_ADDR_W-1:0] addrCtrl   = 'h00;
   localparam logic [`VR_REG_ADDR_W-1:0] addrStatus = 'h04;
   localparam logic [`VR_REG_ADDR_W-1:0] addrExt    = 'h08;
   localparam logic [`VR_REG_ADDR_W-1:0] addrBuf    = 'h0C;
   localparam logic [`VR_REG_ADDR_W-1:0] addrIter   = 'h10;
   localparam logic [`VR_REG_ADDR_W-1:0] addrStride = 'h14;
   localparam logic [`VR_REG_ADDR_W-1:0] addrOuter  = 'h18;

   logic                    wrFire;
   logic                    rdFire;
   logic                    doneA;
   logic                    doneB;
   logic [`VR_DATA_W-1:0]   rdMux;

   // address and data are taken in the same handshake
   assign wready = awready;
   assign wrFire = awvalid & wvalid & awready;
   assign rdFire = arvalid & arready;
   assign bresp  = 2'b00;
   assign rresp  = 2'b00;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         awready <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         runA    <= 1'b0;
         runB    <= 1'b0;
         doneA   <= 1'b0;
         doneB   <= 1'b0;
      end
      else
      begin
         awready <= awvalid & wvalid & ~awready & ~bvalid;
         arready <= arvalid & ~arready & ~rvalid;
         if (wrFire)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         if (rdFire)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
         runA <= wrFire && awaddr == addrCtrl && wdata[0];
         runB <= wrFire && awaddr == addrCtrl && wdata[1];
         // sticky status cleared by a new run
         if (runA)
            doneA <= 1'b0;
         else if (finishA)
            doneA <= 1'b1;
         if (runB)
            doneB <= 1'b0;
         else if (finishB)
            doneB <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         cfg <= '0;
      else if (wrFire)
      begin
         case (awaddr)
            addrExt:
               cfg.extAddr <= wdata;
            addrBuf:
            begin
               cfg.intAddr <= wdata[0 +: `VR_MEM_ADDR_W];
               cfg.size    <= wdata[16 +: `VR_SIZE_W];
            end
            addrIter:
            begin
               cfg.iter  <= wdata[0 +: `VR_MEM_ADDR_W];
               cfg.per   <= wdata[8 +: `VR_PERIOD_W];
               cfg.duty  <= wdata[16 +: `VR_PERIOD_W];
               cfg.delay <= wdata[24 +: `VR_PERIOD_W];
            end
            addrStride:
            begin
               cfg.start <= wdata[0 +: `VR_MEM_ADDR_W];
               cfg.incr  <= wdata[8 +: `VR_MEM_ADDR_W];
               cfg.shift <= wdata[16 +: `VR_MEM_ADDR_W];
            end
            addrOuter:
            begin
               cfg.iter2   <= wdata[0 +: `VR_MEM_ADDR_W];
               cfg.incr2   <= wdata[8 +: `VR_MEM_ADDR_W];
               cfg.reverse <= wdata[16];
            end
            default: ;
         endcase
      end
   end

   // readback uses the write layout and CTRL reads as zero
   always_comb
   begin
      rdMux = '0;
      case (araddr)
         addrStatus:
            rdMux[1:0] = {doneB, doneA};
         addrExt:
            rdMux = cfg.extAddr;
         addrBuf:
         begin
            rdMux[0 +: `VR_MEM_ADDR_W] = cfg.intAddr;
            rdMux[16 +: `VR_SIZE_W]    = cfg.size;
         end
         addrIter:
         begin
            rdMux[0 +: `VR_MEM_ADDR_W] = cfg.iter;
            rdMux[8 +: `VR_PERIOD_W]   = cfg.per;
            rdMux[16 +: `VR_PERIOD_W]  = cfg.duty;
            rdMux[24 +: `VR_PERIOD_W]  = cfg.delay;
         end
         addrStride:
         begin
            rdMux[0 +: `VR_MEM_ADDR_W]  = cfg.start;
            rdMux[8 +: `VR_MEM_ADDR_W]  = cfg.incr;
            rdMux[16 +: `VR_MEM_ADDR_W] = cfg.shift;
         end
         addrOuter:
         begin
            rdMux[0 +: `VR_MEM_ADDR_W] = cfg.iter2;
            rdMux[8 +: `VR_MEM_ADDR_W] = cfg.incr2;
            rdMux[16]                  = cfg.reverse;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rdFire)
         rdata <= rdMux;
   end

   // one write response outstanding at a time
   oneResp: assert property (@(posedge clk) disable iff (!arstN)
      wrFire |-> !bvalid);

endmodule

`default_nettype wire

// File: hw/vreadTop.sv
`default_nettype none

`include "vread_defs.svh"

module vreadTop (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic [`VR_REG_ADDR_W-1:0]   awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [`VR_DATA_W-1:0]       wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [`VR_REG_ADDR_W-1:0]   araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [`VR_DATA_W-1:0]       rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   output logic                        databusValid,
   output logic [`VR_IO_ADDR_W-1:0]    databusAddr,
   input  logic                        databusReady,
   input  logic [`VR_DATA_W-1:0]       databusRdata,
   output logic                        flowValid,
   output logic [`VR_DATA_W-1:0]       flowOut
);

   vreadPkg::vreadCfgT  cfg;
   logic                runA;
   logic                runB;
   logic                finishA;
   logic                finishB;

   memPortIf memPort ();

   vreadCtrl ctrl (.*);

   extReadEngine fetch (
      .clk           (clk),
      .arstN         (arstN),
      .run           (runA),
      .cfg           (cfg),
      .finish        (finishA),
      .databusValid  (databusValid),
      .databusAddr   (databusAddr),
      .databusReady  (databusReady),
      .databusRdata  (databusRdata),
      .mem           (memPort.fill)
   );

   streamAddrGen drain (
      .clk     (clk),
      .arstN   (arstN),
      .run     (runB),
      .cfg     (cfg),
      .finish  (finishB),
      .mem     (memPort.drain)
   );

   streamBuffer buffer (
      .clk  (clk),
      .mem  (memPort.store)
   );

   // valid follows the buffer read latency
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         flowValid <= 1'b0;
      else
         flowValid <= memPort.rdEn;
   end

   assign flowOut = memPort.rdData;

endmodule

`default_nettype wire

// File: sim/extMemModel.sv
`default_nettype none

`include "vread_defs.svh"

module extMemModel #(
   parameter int seedInit = 32'h6715f329
) (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic                        valid,
   input  logic [`VR_IO_ADDR_W-1:0]    addr,
   output logic                        ready,
   output logic [`VR_DATA_W-1:0]       rdata
);

   timeunit 1ns;
   timeprecision 1ps;

   integer seed = seedInit;

   // ready is low in about one cycle of four
   always @(negedge clk or negedge arstN)
   begin
      if (!arstN)
         ready <= 1'b0;
      else
         ready <= ($random(seed) & 3) != 0;
   end

   // memory content is a function of the byte address
   assign rdata = addr ^ 32'hA5A5_0000;

endmodule

`default_nettype wire

// File: sim/vreadTb.sv
`default_nettype none

`include "vread_defs.svh"

module vreadTb #(
   parameter int randSeed = 32'h6715f329
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int numRows = 4;

   // fetch 64 words, linear; duty below per; outer loop with wrap; bit reverse
   localparam vreadPkg::vreadCfgT rows [numRows] = '{
      '{extAddr: 32'h0000_1000, intAddr: 6'd0, size: 7'd64, iter: 6'd32, per: 5'd1,
        duty: 5'd1, delay: 5'd0, start: 6'd0, incr: 6'd1, shift: 6'd1, iter2: 6'd1,
        incr2: 6'd0, reverse: 1'b0},
      '{extAddr: 32'h0000_2000, intAddr: 6'd8, size: 7'd32, iter: 6'd4, per: 5'd5,
        duty: 5'd3, delay: 5'd4, start: 6'd10, incr: 6'd2, shift: 6'd7, iter2: 6'd1,
        incr2: 6'd0, reverse: 1'b0},
      '{extAddr: 32'h0003_0000, intAddr: 6'd40, size: 7'd48, iter: 6'd3, per: 5'd2,
        duty: 5'd2, delay: 5'd1, start: 6'd50, incr: 6'd3, shift: 6'd5, iter2: 6'd3,
        incr2: 6'd9, reverse: 1'b0},
      '{extAddr: 32'h0000_0040, intAddr: 6'd0, size: 7'd64, iter: 6'd4, per: 5'd3,
        duty: 5'd2, delay: 5'd2, start: 6'd1, incr: 6'd1, shift: 6'd4, iter2: 6'd2,
        incr2: 6'd16, reverse: 1'b1}
   };
   localparam int expWords [numRows] = '{32, 12, 18, 16};

   logic                         clk = 1'b0;
   logic                         arstN;
   logic [`VR_REG_ADDR_W-1:0]    awaddr;
   logic                         awvalid;
   logic                         awready;
   logic [`VR_DATA_W-1:0]        wdata;
   logic                         wvalid;
   logic                         wready;
   logic [1:0]                   bresp;
   logic                         bvalid;
   logic                         bready;
   logic [`VR_REG_ADDR_W-1:0]    araddr;
   logic                         arvalid;
   logic                         arready;
   logic [`VR_DATA_W-1:0]        rdata;
   logic [1:0]                   rresp;
   logic                         rvalid;
   logic                         rready;
   logic                         databusValid;
   logic [`VR_IO_ADDR_W-1:0]     databusAddr;
   logic                         databusReady;
   logic [`VR_DATA_W-1:0]        databusRdata;
   logic                         flowValid;
   logic [`VR_DATA_W-1:0]        flowOut;

   logic [`VR_DATA_W-1:0]        flowQ [$];
   logic [`VR_DATA_W-1:0]        shadow [64];

   vreadTop uut (.*);

   extMemModel #(.seedInit(randSeed)) extMem (
      .clk    (clk),
      .arstN  (arstN),
      .valid  (databusValid),
      .addr   (databusAddr),
      .ready  (databusReady),
      .rdata  (databusRdata)
   );

   always #50 clk = ~clk;

   // outputs are stable at the falling edge
   always @(negedge clk)
   begin
      if (flowValid)
         flowQ.push_back(flowOut);
   end

   task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
         $display("Some tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic writeReg(input logic [5:0] addr, input logic [31:0] data);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge clk);
      while (!awready)
         @(negedge clk);
      checkVal("wready", 32'(wready), 32'h1);
      @(negedge clk);
      checkVal("bvalid", 32'(bvalid), 32'h1);
      checkVal("bresp", 32'(bresp), 32'h0);
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   task automatic readReg(input logic [5:0] addr, output logic [31:0] data);
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready)
         @(negedge clk);
      @(negedge clk);
      checkVal("rvalid", 32'(rvalid), 32'h1);
      checkVal("rresp", 32'(rresp), 32'h0);
      data    = rdata;
      arvalid = 1'b0;
   endtask

   task automatic waitDone(input int bitIdx);
      logic [31:0] st;
      st = '0;
      while (st[bitIdx] !== 1'b1)
         readReg(6'h04, st);
   endtask

   task automatic runRow(input int r);
      vreadPkg::vreadCfgT c;
      logic [5:0] a;
      logic [31:0] expQ [$];
      c = rows[r];
      writeReg(6'h08, c.extAddr);
      writeReg(6'h0C, {9'd0, c.size, 10'd0, c.intAddr});
      writeReg(6'h10, {3'd0, c.delay, 3'd0, c.duty, 3'd0, c.per, 2'd0, c.iter});
      writeReg(6'h14, {10'd0, c.shift, 2'd0, c.incr, 2'd0, c.start});
      writeReg(6'h18, {15'd0, c.reverse, 2'd0, c.incr2, 2'd0, c.iter2});
      writeReg(6'h00, 32'h1);
      waitDone(0);
      // word n of the fetch lands at intAddr+n
      for (int n = 0; n < int'(c.size); n++)
      begin
         a = c.intAddr + 6'(n);
         shadow[a] = (c.extAddr + 32'(4 * n)) ^ 32'hA5A5_0000;
      end
      checkVal("flowValid words before stream", flowQ.size(), 32'd0);
      writeReg(6'h00, 32'h2);
      waitDone(1);
      for (int o = 0; o < int'(c.iter2); o++)
         for (int i = 0; i < int'(c.iter); i++)
            for (int k = 0; k < int'(c.duty); k++)
            begin
               a = 6'(int'(c.start) + o * int'(c.incr2) + i * int'(c.shift)
                  + k * int'(c.incr));
               if (c.reverse)
                  a = {<<{a}};
               expQ.push_back(shadow[a]);
            end
      checkVal("reference word count", expQ.size(), expWords[r]);
      checkVal("flowValid word count", flowQ.size(), expWords[r]);
      for (int n = 0; n < expQ.size(); n++)
         checkVal($sformatf("flowOut row %0d word %0d", r, n), flowQ[n], expQ[n]);
      flowQ.delete();
   endtask

   initial
   begin
      logic [31:0] st;
      arstN   = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b1;
      repeat (8) @(negedge clk);
      arstN = 1'b1;
      readReg(6'h04, st);
      checkVal("STATUS after reset", st, 32'h0);
      checkVal("flowValid words after reset", flowQ.size(), 32'd0);
      for (int r = 0; r < numRows; r++)
         runRow(r);
      readReg(6'h04, st);
      checkVal("STATUS at end", st, 32'h3);
      $display("All tests passed");
      $finish;
   end

   // per row a stalled fetch, the full stream and register traffic
   initial
   begin
      int limit;
      limit = 8;
      for (int r = 0; r < numRows; r++)
         limit += 8 * int'(rows[r].size) + int'(rows[r].delay)
            + int'(rows[r].iter2) * int'(rows[r].iter) * int'(rows[r].per) + 200;
      limit *= 4;
      repeat (limit) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Some tests failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/vreadPkg.sv
hw/memPortIf.sv
hw/streamBuffer.sv
hw/extReadEngine.sv
hw/streamAddrGen.sv
hw/vreadCtrl.sv
hw/vreadTop.sv
sim/extMemModel.sv
sim/vreadTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vreadTb
LOG       ?= sim.log
BUILD     ?= obj_dir
# decimal form of 32'h6715f329
SEED      ?= 1729491753

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		-GrandSeed=$(SEED) -Mdir $(BUILD) -f list.f
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
